// ==== vlog.f ====
+incdir+sim
hdl/cache_pkg.sv
hdl/cache_req_reg.sv
hdl/cache_way.sv
hdl/cache_lru.sv
hdl/cache_hit_merge.sv
hdl/cache_stage1.sv
sim/tb_cache_stage1.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cache stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
    --top-module tb_cache_stage1 -o tb_cache_stage1
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_cache_stage1 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"
exit 0

// ==== sim/tb_cache_tests.svh ====
function automatic cache_pkg::paddr_t make_addr(input int tag, input int set, input int offset);
    return {cache_pkg::tag_t'(tag), cache_pkg::index_t'(set), 5'(offset)};
endfunction

function automatic cache_pkg::cache_req_t make_req(input cache_pkg::paddr_t addr,
        input logic write, input cache_pkg::line_t data, input cache_pkg::byte_mask_t mask);
    cache_pkg::cache_req_t r;
    r.addr      = addr;
    r.write     = write;
    r.data      = data;
    r.byte_mask = mask;
    return r;
endfunction

// Returns in the cycle whose rising edge accepts the request
task automatic issue_req(input cache_pkg::cache_req_t r);
    @(negedge clk);
    req_valid = 1'b1;
    req       = r;
    #1;
    while (stall) begin
        @(negedge clk);
        #1;
    end
endtask

task automatic idle_req();
    @(negedge clk);
    req_valid = 1'b0;
    #1;
endtask

task automatic wait_resp(output cache_pkg::cache_resp_t got, output int got_cycle);
    int n;
    n = 0;
    got = '0;
    got_cycle = 0;
    while (resp_q.size() == 0 && n < RESP_WAIT) begin
        @(negedge clk);
        #1;
        n++;
    end
    if (resp_q.size() != 0) begin
        got       = resp_q.pop_front();
        got_cycle = resp_cycle_q.pop_front();
    end else begin
        $display("No response arrived within %0d cycles at %0t", RESP_WAIT, $time);
        err_count++;
    end
endtask

task automatic run_access(input cache_pkg::cache_req_t r, output cache_pkg::cache_resp_t got);
    cache_pkg::cache_resp_t exp;
    bit use_line;
    int c;
    predict_resp(r, exp, use_line);
    issue_req(r);
    idle_req();
    wait_resp(got, c);
    check_resp("resp", got, exp, use_line);
endtask

task automatic do_fill(input cache_pkg::paddr_t addr, input cache_pkg::line_t l);
    @(negedge clk);
    fill_valid = 1'b1;
    fill.addr  = addr;
    fill.line  = l;
    model_fill(addr, l);
    @(negedge clk);
    fill_valid = 1'b0;
endtask

task automatic test_read_fill();
    cache_pkg::paddr_t a;
    cache_pkg::line_t l;
    cache_pkg::cache_resp_t got;
    a = make_addr(8'h3c, 1, 7);
    l = rand_line();
    run_access(make_req(a, 1'b0, '0, '0), got);
    check_addr("resp.ext_addr", got.ext_addr, {a[14:5], 5'd0});
    do_fill(a, l);
    run_access(make_req(a, 1'b0, '0, '0), got);
    check_line("resp.line", got.line, l);
endtask

task automatic test_write_merge();
    cache_pkg::paddr_t a;
    cache_pkg::line_t l;
    cache_pkg::line_t d;
    cache_pkg::line_t exp_line;
    cache_pkg::byte_mask_t m;
    cache_pkg::cache_resp_t got;
    a = make_addr(8'h4a, 2, 3);
    l = rand_line();
    d = rand_line();
    m = cache_pkg::byte_mask_t'(next_rand());
    exp_line = l;
    for (int b = 0; b < cache_pkg::LINE_BYTES; b++)
        if (m[b])
            exp_line[b*8 +: 8] = d[b*8 +: 8];
    do_fill(a, l);
    run_access(make_req(a, 1'b1, d, m), got);
    run_access(make_req(a, 1'b0, '0, '0), got);
    check_line("resp.line", got.line, exp_line);
endtask

task automatic test_lru_fill();
    cache_pkg::line_t l5;
    cache_pkg::cache_resp_t got;
    for (int i = 0; i < 4; i++)
        do_fill(make_addr(8'h10 + i, 3, i), rand_line());
    l5 = rand_line();
    do_fill(make_addr(8'h14, 3, 0), l5);
    run_access(make_req(make_addr(8'h10, 3, 9), 1'b0, '0, '0), got);
    if (!got.miss) begin
        $display("First address of set 3 still hits after the fifth fill at %0t", $time);
        err_count++;
    end
    run_access(make_req(make_addr(8'h14, 3, 2), 1'b0, '0, '0), got);
    check_line("resp.line", got.line, l5);
endtask

task automatic test_lru_writeback();
    int v;
    cache_pkg::tag_t vtag;
    cache_pkg::cache_resp_t got;
    for (int i = 0; i < 4; i++)
        do_fill(make_addr(8'h20 + i, 0, 0), rand_line());
    run_access(make_req(make_addr(8'h22, 0, 1), 1'b0, '0, '0), got);
    run_access(make_req(make_addr(8'h20, 0, 1), 1'b0, '0, '0), got);
    run_access(make_req(make_addr(8'h23, 0, 1), 1'b0, '0, '0), got);
    // Clean miss returns the victim line picked from the reordered ages
    run_access(make_req(make_addr(8'h2e, 0, 1), 1'b0, '0, '0), got);
    // Every way dirty, so any victim needs a write-back
    for (int i = 0; i < 4; i++)
        run_access(make_req(make_addr(8'h20 + i, 0, 3), 1'b1, rand_line(),
                            cache_pkg::byte_mask_t'(next_rand())), got);
    v    = model_victim(0);
    vtag = m_tag[0][v];
    run_access(make_req(make_addr(8'h2f, 0, 4), 1'b0, '0, '0), got);
    check_addr("resp.ext_addr", got.ext_addr, {vtag, 2'd0, 5'd0});
    if (!got.writeback) begin
        $display("Miss on a dirty victim gave no write-back at %0t", $time);
        err_count++;
    end
endtask

task automatic test_stall();
    cache_pkg::cache_req_t ra;
    cache_pkg::cache_req_t rb;
    cache_pkg::cache_resp_t exp_a;
    cache_pkg::cache_resp_t exp_b;
    cache_pkg::cache_resp_t got;
    bit ul_a;
    bit ul_b;
    int c;
    do_fill(make_addr(8'h61, 1, 0), rand_line());
    ra = make_req(make_addr(8'h55, 1, 2), 1'b0, '0, '0);
    rb = make_req(make_addr(8'h61, 1, 6), 1'b0, '0, '0);
    predict_resp(ra, exp_a, ul_a);
    predict_resp(rb, exp_b, ul_b);
    @(negedge clk);
    mshr_full = 1'b1;
    issue_req(ra);
    @(negedge clk);
    req = rb;
    for (int i = 0; i < 5; i++) begin
        #1;
        if (!stall || resp_q.size() != 0) begin
            $display("Stall did not hold the missing request at %0t", $time);
            err_count++;
        end
        @(negedge clk);
    end
    mshr_full = 1'b0;
    #1;
    if (stall) begin
        $display("Stall stayed high after the miss queue freed up at %0t", $time);
        err_count++;
    end
    idle_req();
    wait_resp(got, c);
    check_resp("resp", got, exp_a, ul_a);
    wait_resp(got, c);
    check_resp("resp", got, exp_b, ul_b);
    repeat (3) @(negedge clk);
    #1;
    if (resp_q.size() != 0) begin
        $display("Extra responses after the stall ended at %0t", $time);
        err_count++;
    end
endtask

task automatic test_back_to_back();
    cache_pkg::cache_req_t ra;
    cache_pkg::cache_req_t rb;
    cache_pkg::cache_resp_t exp_a;
    cache_pkg::cache_resp_t exp_b;
    cache_pkg::cache_resp_t got;
    bit ul_a;
    bit ul_b;
    int issue_a;
    int issue_b;
    int c;
    do_fill(make_addr(8'h70, 2, 0), rand_line());
    do_fill(make_addr(8'h71, 3, 0), rand_line());
    ra = make_req(make_addr(8'h70, 2, 5), 1'b0, '0, '0);
    rb = make_req(make_addr(8'h71, 3, 8), 1'b0, '0, '0);
    predict_resp(ra, exp_a, ul_a);
    predict_resp(rb, exp_b, ul_b);
    issue_req(ra);
    issue_a = cycle;
    issue_req(rb);
    issue_b = cycle;
    idle_req();
    wait_resp(got, c);
    check_resp("resp", got, exp_a, ul_a);
    if (c != issue_a + 2) begin
        $display("ERROR %0t resp_valid cycle: got %0d exp %0d", $time, c, issue_a + 2);
        err_count++;
    end
    wait_resp(got, c);
    check_resp("resp", got, exp_b, ul_b);
    if (c != issue_b + 2) begin
        $display("ERROR %0t resp_valid cycle: got %0d exp %0d", $time, c, issue_b + 2);
        err_count++;
    end
endtask

// ==== sim/tb_cache_stage1.sv ====
`timescale 1ns/1ps

module tb_cache_stage1;

    localparam int RESET_CYCLES    = 8;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 100;
    localparam int CYCLE_LIMIT     = RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST;
    localparam int RESP_WAIT       = 20;
    localparam int NS              = cache_pkg::NUM_SETS;
    localparam int NW              = cache_pkg::NUM_WAYS;

    logic                   clk;
    logic                   rst_n;
    logic                   req_valid;
    cache_pkg::cache_req_t  req;
    logic                   fill_valid;
    cache_pkg::cache_fill_t fill;
    logic                   mshr_full;
    logic                   stall;
    logic                   resp_valid;
    cache_pkg::cache_resp_t resp;

    int          cycle = 0;
    int          err_count = 0;
    int          tests_failed = 0;
    logic [31:0] rng_state = 32'he336_f1c6;

    cache_pkg::cache_resp_t resp_q [$];
    int                     resp_cycle_q [$];

    // Reference model, one entry per set and way
    cache_pkg::tag_t  m_tag   [NS][NW];
    logic             m_valid [NS][NW];
    logic             m_dirty [NS][NW];
    cache_pkg::line_t m_line  [NS][NW];
    int               m_age   [NS][NW];

    cache_stage1 DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .fill_valid (fill_valid),
        .fill       (fill),
        .mshr_full  (mshr_full),
        .stall      (stall),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && resp_valid) begin
            resp_q.push_back(resp);
            resp_cycle_q.push_back(cycle);
        end
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic cache_pkg::line_t rand_line();
        cache_pkg::line_t l;
        for (int i = 0; i < 4; i++)
            l[i*32 +: 32] = next_rand();
        return l;
    endfunction

    task automatic check_resp(input string name, input cache_pkg::cache_resp_t got,
                              input cache_pkg::cache_resp_t exp, input bit use_line);
        cache_pkg::cache_resp_t g;
        g = got;
        // Line of an invalid victim carries no meaning
        if (!use_line)
            g.line = exp.line;
        if (g !== exp) begin
            $display("ERROR %0t %s: got %h exp %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_line(input string name, input cache_pkg::line_t got,
                              input cache_pkg::line_t exp);
        if (got !== exp) begin
            $display("ERROR %0t %s: got %h exp %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_addr(input string name, input cache_pkg::paddr_t got,
                              input cache_pkg::paddr_t exp);
        if (got !== exp) begin
            $display("ERROR %0t %s: got %h exp %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    function automatic void model_reset();
        for (int s = 0; s < NS; s++) begin
            for (int w = 0; w < NW; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_age[s][w]   = 0;
            end
        end
    endfunction

    // Invalid ways first, then the oldest, lowest number on a tie
    function automatic int model_victim(input int set);
        int oldest;
        for (int w = 0; w < NW; w++)
            if (!m_valid[set][w])
                return w;
        oldest = 0;
        for (int w = 1; w < NW; w++)
            if (m_age[set][w] > m_age[set][oldest])
                oldest = w;
        return oldest;
    endfunction

    function automatic void model_touch(input int set, input int way);
        int old;
        old = m_age[set][way];
        for (int w = 0; w < NW; w++)
            if (m_age[set][w] < old)
                m_age[set][w]++;
        m_age[set][way] = 0;
    endfunction

    // Expected response, applying the write and the touch of an accepted request
    function automatic void predict_resp(input cache_pkg::cache_req_t r,
                                         output cache_pkg::cache_resp_t e, output bit use_line);
        int set;
        int hw;
        int v;
        cache_pkg::tag_t t;
        set = int'(r.addr[6:5]);
        t   = r.addr[14:7];
        hw  = -1;
        for (int w = NW - 1; w >= 0; w--)
            if (m_valid[set][w] && m_tag[set][w] == t)
                hw = w;
        e = '0;
        e.ext_addr = {t, r.addr[6:5], 5'd0};
        if (hw >= 0) begin
            e.hit    = 1'b1;
            e.line   = m_line[set][hw];
            use_line = 1'b1;
            if (r.write) begin
                for (int b = 0; b < cache_pkg::LINE_BYTES; b++)
                    if (r.byte_mask[b])
                        m_line[set][hw][b*8 +: 8] = r.data[b*8 +: 8];
                m_dirty[set][hw] = 1'b1;
            end
            model_touch(set, hw);
        end else begin
            v        = model_victim(set);
            e.miss   = 1'b1;
            e.line   = m_line[set][v];
            use_line = m_valid[set][v];
            if (m_dirty[set][v]) begin
                e.writeback = 1'b1;
                e.ext_addr  = {m_tag[set][v], r.addr[6:5], 5'd0};
            end else begin
                e.fetch = 1'b1;
            end
        end
    endfunction

    function automatic void model_fill(input cache_pkg::paddr_t addr, input cache_pkg::line_t l);
        int set;
        int v;
        set = int'(addr[6:5]);
        v   = model_victim(set);
        m_tag[set][v]   = addr[14:7];
        m_valid[set][v] = 1'b1;
        m_dirty[set][v] = 1'b0;
        m_line[set][v]  = l;
        model_touch(set, v);
    endfunction

    function automatic void report_test(input string name, input int start_err);
        if (err_count == start_err) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, err_count - start_err);
        end
    endfunction

    `include "tb_cache_tests.svh"

    initial begin
        int start_err;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        fill_valid = 1'b0;
        fill       = '0;
        mshr_full  = 1'b0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        start_err = err_count;
        test_read_fill();
        report_test("read miss then fill", start_err);
        start_err = err_count;
        test_write_merge();
        report_test("masked write hit", start_err);
        start_err = err_count;
        test_lru_fill();
        report_test("fifth fill replacement", start_err);
        start_err = err_count;
        test_lru_writeback();
        report_test("age reorder and write-back", start_err);
        start_err = err_count;
        test_stall();
        report_test("stall on full miss queue", start_err);
        start_err = err_count;
        test_back_to_back();
        report_test("back-to-back hits", start_err);
        $display("Summary: %0d tests, %0d failing, %0d errors",
                 NUM_TESTS, tests_failed, err_count);
        if (err_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// ==== hdl/cache_stage1.sv ====
`timescale 1ns/1ps

module cache_stage1 (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  cache_pkg::cache_req_t  req,
    input  logic                   fill_valid,
    input  cache_pkg::cache_fill_t fill,
    input  logic                   mshr_full,
    output logic                   stall,
    output logic                   resp_valid,
    output cache_pkg::cache_resp_t resp
);

    logic                  pend_valid;
    cache_pkg::cache_req_t pend;
    cache_pkg::tag_t       pend_tag;
    cache_pkg::index_t     pend_index;

    cache_pkg::way_vec_t   hits;
    cache_pkg::way_vec_t   dirties;
    cache_pkg::way_vec_t   valids;
    cache_pkg::way_vec_t   fill_valids;
    cache_pkg::way_vec_t   write_en;
    cache_pkg::line_t      lines [cache_pkg::NUM_WAYS];
    cache_pkg::tag_t       tags  [cache_pkg::NUM_WAYS];

    cache_pkg::way_id_t    victim;
    cache_pkg::way_id_t    fill_victim;
    logic                  touch;
    cache_pkg::way_id_t    touch_way;

    cache_pkg::index_t     fill_index;
    cache_pkg::tag_t       fill_tag;

    assign fill_index = fill.addr[cache_pkg::INDEX_LSB +: cache_pkg::INDEX_W];
    assign fill_tag   = fill.addr[cache_pkg::TAG_LSB +: cache_pkg::TAG_W];

    cache_req_reg u_req_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .stall      (stall),
        .pend_valid (pend_valid),
        .pend       (pend),
        .pend_tag   (pend_tag),
        .pend_index (pend_index)
    );

    for (genvar w = 0; w < cache_pkg::NUM_WAYS; w++) begin : g_way
        logic way_fill_en;

        // Fill goes to the LRU victim of its set
        assign way_fill_en = fill_valid && (fill_victim == cache_pkg::way_id_t'(w));

        cache_way u_way (
            .clk            (clk),
            .rst_n          (rst_n),
            .lookup_index   (pend_index),
            .lookup_tag     (pend_tag),
            .write_en       (write_en[w]),
            .write_data     (pend.data),
            .write_mask     (pend.byte_mask),
            .fill_en        (way_fill_en),
            .fill_index     (fill_index),
            .fill_tag       (fill_tag),
            .fill_line      (fill.line),
            .hit            (hits[w]),
            .line           (lines[w]),
            .dirty          (dirties[w]),
            .valid          (valids[w]),
            .tag            (tags[w]),
            .fill_set_valid (fill_valids[w])
        );
    end

    cache_lru u_lru (
        .clk            (clk),
        .rst_n          (rst_n),
        .index          (pend_index),
        .valid_vec      (valids),
        .fill_index     (fill_index),
        .fill_valid_vec (fill_valids),
        .touch          (touch),
        .touch_way      (touch_way),
        .fill_en        (fill_valid),
        .victim         (victim),
        .fill_victim    (fill_victim)
    );

    cache_hit_merge u_hit_merge (
        .clk        (clk),
        .rst_n      (rst_n),
        .pend_valid (pend_valid),
        .pend       (pend),
        .hits       (hits),
        .lines      (lines),
        .dirties    (dirties),
        .tags       (tags),
        .victim     (victim),
        .mshr_full  (mshr_full),
        .stall      (stall),
        .write_en   (write_en),
        .touch      (touch),
        .touch_way  (touch_way),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

// ==== hdl/cache_hit_merge.sv ====
`timescale 1ns/1ps

module cache_hit_merge (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pend_valid,
    input  cache_pkg::cache_req_t pend,
    input  cache_pkg::way_vec_t   hits,
    input  cache_pkg::line_t      lines [cache_pkg::NUM_WAYS],
    input  cache_pkg::way_vec_t   dirties,
    input  cache_pkg::tag_t       tags [cache_pkg::NUM_WAYS],
    input  cache_pkg::way_id_t    victim,
    input  logic                  mshr_full,
    output logic                  stall,
    output cache_pkg::way_vec_t   write_en,
    output logic                  touch,
    output cache_pkg::way_id_t    touch_way,
    output logic                  resp_valid,
    output cache_pkg::cache_resp_t resp
);

    logic                   any_hit;
    logic                   miss;
    logic                   victim_dirty;
    logic                   accept;
    cache_pkg::way_id_t     hit_way;
    cache_pkg::tag_t        req_tag;
    cache_pkg::index_t      req_index;
    cache_pkg::cache_resp_t resp_d;

    assign req_tag   = pend.addr[cache_pkg::TAG_LSB +: cache_pkg::TAG_W];
    assign req_index = pend.addr[cache_pkg::INDEX_LSB +: cache_pkg::INDEX_W];

    // One-hot hits in practice, lowest way wins anyway
    always_comb begin
        hit_way = '0;
        for (int w = cache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (hits[w]) begin
                hit_way = cache_pkg::way_id_t'(w);
            end
        end
    end

    assign any_hit      = |hits;
    assign miss         = pend_valid && !any_hit;
    assign victim_dirty = dirties[victim];

    // Miss with no room in the miss queue holds the pending request
    assign stall  = miss && mshr_full;
    assign accept = pend_valid && !stall;

    // Hits never stall, so the write lands with the response
    assign write_en  = (pend_valid && pend.write) ? hits : '0;
    assign touch     = pend_valid && any_hit;
    assign touch_way = hit_way;

    always_comb begin
        resp_d.hit       = any_hit;
        resp_d.miss      = !any_hit;
        resp_d.writeback = !any_hit && victim_dirty;
        resp_d.fetch     = !any_hit && !victim_dirty;
        // Miss carries the victim line, used as write-back data
        // Write hits return the line as it was before the merge
        resp_d.line      = any_hit ? lines[hit_way] : lines[victim];
        if (resp_d.writeback) begin
            resp_d.ext_addr = {tags[victim], req_index, {cache_pkg::OFFSET_W{1'b0}}};
        end else begin
            resp_d.ext_addr = {req_tag, req_index, {cache_pkg::OFFSET_W{1'b0}}};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resp <= resp_d;
        end
    end

endmodule

// ==== hdl/cache_lru.sv ====
`timescale 1ns/1ps

module cache_lru (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::index_t   index,
    input  cache_pkg::way_vec_t valid_vec,
    input  cache_pkg::index_t   fill_index,
    input  cache_pkg::way_vec_t fill_valid_vec,
    input  logic                touch,
    input  cache_pkg::way_id_t  touch_way,
    input  logic                fill_en,
    output cache_pkg::way_id_t  victim,
    output cache_pkg::way_id_t  fill_victim
);

    typedef cache_pkg::age_t [cache_pkg::NUM_WAYS-1:0] age_vec_t;

    age_vec_t ages_q [cache_pkg::NUM_SETS];

    // Lowest invalid way, else the oldest way with the lowest number on a tie
    function automatic cache_pkg::way_id_t pick_victim(
        input cache_pkg::way_vec_t vld,
        input age_vec_t            ages
    );
        cache_pkg::way_id_t v;
        cache_pkg::age_t    oldest;
        v      = '0;
        oldest = ages[0];
        for (int w = 1; w < cache_pkg::NUM_WAYS; w++) begin
            if (ages[w] > oldest) begin
                oldest = ages[w];
                v      = cache_pkg::way_id_t'(w);
            end
        end
        for (int w = cache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (!vld[w]) begin
                v = cache_pkg::way_id_t'(w);
            end
        end
        return v;
    endfunction

    // Touched way becomes youngest, younger ways age by one
    function automatic age_vec_t touch_ages(
        input age_vec_t           ages,
        input cache_pkg::way_id_t way
    );
        age_vec_t        next;
        cache_pkg::age_t old;
        next = ages;
        old  = ages[way];
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            if (ages[w] < old) begin
                next[w] = ages[w] + 1'b1;
            end
        end
        next[way] = '0;
        return next;
    endfunction

    assign victim      = pick_victim(valid_vec, ages_q[index]);
    assign fill_victim = pick_victim(fill_valid_vec, ages_q[fill_index]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
                ages_q[s] <= '0;
            end
        end else begin
            for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
                if (fill_en && fill_index == cache_pkg::index_t'(s)) begin
                    ages_q[s] <= touch_ages(ages_q[s], fill_victim);
                end else if (touch && index == cache_pkg::index_t'(s)) begin
                    ages_q[s] <= touch_ages(ages_q[s], touch_way);
                end
            end
        end
    end

endmodule

// ==== hdl/cache_way.sv ====
`timescale 1ns/1ps

module cache_way (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cache_pkg::index_t     lookup_index,
    input  cache_pkg::tag_t       lookup_tag,
    input  logic                  write_en,
    input  cache_pkg::line_t      write_data,
    input  cache_pkg::byte_mask_t write_mask,
    input  logic                  fill_en,
    input  cache_pkg::index_t     fill_index,
    input  cache_pkg::tag_t       fill_tag,
    input  cache_pkg::line_t      fill_line,
    output logic                  hit,
    output cache_pkg::line_t      line,
    output logic                  dirty,
    output logic                  valid,
    output cache_pkg::tag_t       tag,
    output logic                  fill_set_valid
);

    cache_pkg::tag_t               tags_q  [cache_pkg::NUM_SETS];
    cache_pkg::line_t              lines_q [cache_pkg::NUM_SETS];
    logic [cache_pkg::NUM_SETS-1:0] valid_q;
    logic [cache_pkg::NUM_SETS-1:0] dirty_q;
    cache_pkg::line_t              merged;

    // Read side for the pending set
    assign line  = lines_q[lookup_index];
    assign tag   = tags_q[lookup_index];
    assign valid = valid_q[lookup_index];
    assign dirty = dirty_q[lookup_index];
    assign hit   = valid && (tag == lookup_tag);

    // LRU needs the valid bit of the set being filled
    assign fill_set_valid = valid_q[fill_index];

    // Byte merge of the write data into the stored line
    always_comb begin
        merged = line;
        for (int b = 0; b < cache_pkg::LINE_BYTES; b++) begin
            if (write_mask[b]) begin
                merged[b*8 +: 8] = write_data[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (fill_en) begin
                valid_q[fill_index] <= 1'b1;
                dirty_q[fill_index] <= 1'b0;
            end
            if (write_en) begin
                dirty_q[lookup_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags_q[fill_index]  <= fill_tag;
            lines_q[fill_index] <= fill_line;
        end
        if (write_en) begin
            lines_q[lookup_index] <= merged;
        end
    end

endmodule

// ==== hdl/cache_req_reg.sv ====
`timescale 1ns/1ps

module cache_req_reg (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    input  cache_pkg::cache_req_t req,
    input  logic                  stall,
    output logic                  pend_valid,
    output cache_pkg::cache_req_t pend,
    output cache_pkg::tag_t       pend_tag,
    output cache_pkg::index_t     pend_index
);

    // Valid bit follows the request side unless the stage is stalled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_valid <= 1'b0;
        end else if (!stall) begin
            pend_valid <= req_valid;
        end
    end

    // Payload held while stalled
    always_ff @(posedge clk) begin
        if (!stall) begin
            pend <= req;
        end
    end

    assign pend_tag   = pend.addr[cache_pkg::TAG_LSB +: cache_pkg::TAG_W];
    assign pend_index = pend.addr[cache_pkg::INDEX_LSB +: cache_pkg::INDEX_W];

endmodule

// ==== hdl/cache_pkg.sv ====
package cache_pkg;

    // Organization
    localparam int NUM_WAYS   = 4;
    localparam int NUM_SETS   = 4;
    localparam int LINE_BYTES = 16;

    // Physical address split: tag 14..7, index 6..5, offset 4..0
    localparam int PADDR_W   = 15;
    localparam int TAG_W     = 8;
    localparam int INDEX_W   = 2;
    localparam int OFFSET_W  = 5;
    localparam int INDEX_LSB = OFFSET_W;
    localparam int TAG_LSB   = OFFSET_W + INDEX_W;

    typedef logic [PADDR_W-1:0]           paddr_t;
    typedef logic [TAG_W-1:0]             tag_t;
    typedef logic [INDEX_W-1:0]           index_t;
    typedef logic [$clog2(NUM_WAYS)-1:0]  way_id_t;
    typedef logic [NUM_WAYS-1:0]          way_vec_t;
    typedef logic [LINE_BYTES*8-1:0]      line_t;
    typedef logic [LINE_BYTES-1:0]        byte_mask_t;

    // LRU age, 0 is most recently used
    typedef logic [$clog2(NUM_WAYS)-1:0]  age_t;

    typedef struct packed {
        paddr_t     addr;
        logic       write;
        line_t      data;
        byte_mask_t byte_mask;
    } cache_req_t;

    typedef struct packed {
        paddr_t addr;
        line_t  line;
    } cache_fill_t;

    // ext_addr is the victim line on writeback, the request line otherwise
    typedef struct packed {
        logic   hit;
        logic   miss;
        logic   writeback;
        logic   fetch;
        line_t  line;
        paddr_t ext_addr;
    } cache_resp_t;

endpackage
